// ==== include/dma_defs.svh ====
// DMA cluster parameters
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Programming cores
`define DMA_NB_CORES 4

// Bus widths
`define DMA_ADDR_W 32
`define DMA_DATA_W 32

// Word-count field of a transfer
`define DMA_LEN_W 16

// Launched transfers waiting for the engine
`define DMA_QUEUE_DEPTH 4

// TCDM window, everything outside goes to the SoC port
`define DMA_TCDM_BASE (32'h1000_0000)
`define DMA_TCDM_SIZE (32'h0010_0000)

`endif

// ==== hw/dma_pkg.sv ====
// DMA shared types
`default_nettype none

`include "dma_defs.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  typedef logic [`DMA_DATA_W-1:0] data_t;
  typedef logic [$clog2(`DMA_NB_CORES)-1:0] core_id_t;

  // One launched transfer
  typedef struct packed {
    addr_t                 src;
    addr_t                 dst;
    logic [`DMA_LEN_W-1:0] len;     // in 32-bit words
    core_id_t              core_id;
  } desc_t;

  typedef enum logic {
    TGT_TCDM,
    TGT_SOC
  } target_e;

  // Word offsets, taken from address bits [4:2]
  typedef enum logic [2:0] {
    REG_SRC    = 3'd0,
    REG_DST    = 3'd1,
    REG_LEN    = 3'd2,
    REG_CMD    = 3'd3,
    REG_STATUS = 3'd4
  } reg_off_e;

endpackage

`default_nettype wire

// ==== hw/dma_mem_if.sv ====
// DMA memory access bus
`timescale 1ns/100ps
`default_nettype none

interface dma_mem_if;

  // wen high means read
  logic           req;
  logic           wen;
  dma_pkg::addr_t add;
  dma_pkg::data_t wdata;
  logic           gnt;
  logic           r_valid;
  dma_pkg::data_t r_rdata;

  modport master (
    output req,
    output wen,
    output add,
    output wdata,
    input  gnt,
    input  r_valid,
    input  r_rdata
  );

  modport slave (
    input  req,
    input  wen,
    input  add,
    input  wdata,
    output gnt,
    output r_valid,
    output r_rdata
  );

endinterface

`default_nettype wire

// ==== hw/dma_cfg_frontend.sv ====
// DMA control register frontend
`timescale 1ns/100ps
`default_nettype none

`include "dma_defs.svh"

module dma_cfg_frontend (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [`DMA_NB_CORES-1:0]             cfg_req_i,
  input  logic [`DMA_NB_CORES-1:0]             cfg_wen_i,
  input  dma_pkg::addr_t [`DMA_NB_CORES-1:0]   cfg_add_i,
  input  dma_pkg::data_t [`DMA_NB_CORES-1:0]   cfg_wdata_i,
  output logic [`DMA_NB_CORES-1:0]             cfg_gnt_o,
  output logic [`DMA_NB_CORES-1:0]             cfg_r_valid_o,
  output dma_pkg::data_t [`DMA_NB_CORES-1:0]   cfg_r_rdata_o,
  input  logic                                 queue_full_i,
  output logic                                 push_o,
  output dma_pkg::desc_t                       push_desc_o
);

  localparam int unsigned NB = `DMA_NB_CORES;

  // Per-core programming state
  dma_pkg::addr_t [NB-1:0]        src_q;
  dma_pkg::addr_t [NB-1:0]        dst_q;
  logic [NB-1:0][`DMA_LEN_W-1:0]  len_q;
  logic [NB-1:0][7:0]             launch_cnt_q;

  dma_pkg::core_id_t  rr_last_q;
  logic [NB-1:0]      cmd_wr;
  logic [NB-1:0]      eligible;
  logic               gnt_valid;
  dma_pkg::core_id_t  gnt_idx;
  dma_pkg::reg_off_e  gnt_off;
  logic               gnt_wr;
  dma_pkg::data_t     rd_value;
  logic [NB-1:0]      r_valid_q;
  dma_pkg::data_t     rdata_q;

  // A command write has to wait while the queue is full
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      cmd_wr[i]   = !cfg_wen_i[i] &&
                    (dma_pkg::reg_off_e'(cfg_add_i[i][4:2]) == dma_pkg::REG_CMD);
      eligible[i] = cfg_req_i[i] && !(cmd_wr[i] && queue_full_i);
    end
  end

  // Round robin search starting at the core after the last winner
  always_comb begin : arbiter
    dma_pkg::core_id_t cand;
    gnt_valid = 1'b0;
    gnt_idx   = rr_last_q;
    for (int k = 1; k <= NB; k++) begin
      cand = dma_pkg::core_id_t'(rr_last_q + k);
      if (!gnt_valid && eligible[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NB; i++) begin
      cfg_gnt_o[i]     = gnt_valid && (gnt_idx == dma_pkg::core_id_t'(i));
      cfg_r_rdata_o[i] = rdata_q;
    end
  end

  assign cfg_r_valid_o = r_valid_q;
  assign gnt_off       = dma_pkg::reg_off_e'(cfg_add_i[gnt_idx][4:2]);
  assign gnt_wr        = !cfg_wen_i[gnt_idx];

  // Zero length launches are accepted but dropped
  assign push_o              = gnt_valid && cmd_wr[gnt_idx] && (len_q[gnt_idx] != '0);
  assign push_desc_o.src     = src_q[gnt_idx];
  assign push_desc_o.dst     = dst_q[gnt_idx];
  assign push_desc_o.len     = len_q[gnt_idx];
  assign push_desc_o.core_id = gnt_idx;

  always_comb begin
    case (gnt_off)
      dma_pkg::REG_SRC:    rd_value = src_q[gnt_idx];
      dma_pkg::REG_DST:    rd_value = dst_q[gnt_idx];
      dma_pkg::REG_LEN:    rd_value = dma_pkg::data_t'(len_q[gnt_idx]);
      dma_pkg::REG_STATUS: rd_value = dma_pkg::data_t'(launch_cnt_q[gnt_idx]);
      default:             rd_value = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      launch_cnt_q <= '0;
      rr_last_q    <= dma_pkg::core_id_t'(NB - 1);
      r_valid_q    <= '0;
    end else begin
      r_valid_q <= cfg_gnt_o;
      if (gnt_valid) begin
        rr_last_q <= gnt_idx;
        if (gnt_wr) begin
          case (gnt_off)
            dma_pkg::REG_SRC: src_q[gnt_idx] <= cfg_wdata_i[gnt_idx];
            dma_pkg::REG_DST: dst_q[gnt_idx] <= cfg_wdata_i[gnt_idx];
            dma_pkg::REG_LEN: len_q[gnt_idx] <= cfg_wdata_i[gnt_idx][`DMA_LEN_W-1:0];
            default: ;
          endcase
        end
      end
      if (push_o) begin
        launch_cnt_q[gnt_idx] <= launch_cnt_q[gnt_idx] + 8'd1;
      end
    end
  end

  // Response word returned one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (gnt_valid) begin
      rdata_q <= gnt_wr ? '0 : rd_value;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dma_desc_queue.sv ====
// DMA descriptor queue
`timescale 1ns/100ps
`default_nettype none

`include "dma_defs.svh"

module dma_desc_queue (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           push_i,
  input  dma_pkg::desc_t push_desc_i,
  output logic           full_o,
  output logic           not_empty_o,
  output dma_pkg::desc_t head_o,
  input  logic           pop_i
);

  localparam int unsigned DEPTH = `DMA_QUEUE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  dma_pkg::desc_t   mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign full_o      = (count_q == CNT_W'(DEPTH));
  assign not_empty_o = (count_q != '0);
  assign head_o      = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the level unchanged
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_desc_i;
    end
  end

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (rst_i) push_i |-> !full_o
  ) else $error("descriptor queue overflow");

  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (rst_i) pop_i |-> not_empty_o
  ) else $error("descriptor queue underflow");

endmodule

`default_nettype wire

// ==== hw/dma_burst_engine.sv ====
// DMA word copy engine
`timescale 1ns/100ps
`default_nettype none

`include "dma_defs.svh"

module dma_burst_engine (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      desc_valid_i,
  input  dma_pkg::desc_t            desc_i,
  output logic                      pop_o,
  dma_mem_if.master                 eng_bus,
  output logic [`DMA_NB_CORES-1:0]  term_event_o,
  output logic                      active_o
);

  typedef enum logic [1:0] {
    IDLE,
    READ,
    WAIT_DATA,
    WRITE
  } state_e;

  state_e                    state_q;
  logic [`DMA_LEN_W-1:0]     left_q;
  logic [`DMA_NB_CORES-1:0]  term_q;
  dma_pkg::addr_t            src_q;
  dma_pkg::addr_t            dst_q;
  dma_pkg::data_t            data_q;
  dma_pkg::core_id_t         cur_core_q;
  logic                      start;

  // The head is still the finished transfer during the pop cycle
  assign start = (state_q == IDLE) && desc_valid_i && !pop_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      left_q  <= '0;
      term_q  <= '0;
    end else begin
      term_q <= '0;
      case (state_q)
        IDLE: begin
          if (start) begin
            left_q  <= desc_i.len;
            state_q <= READ;
          end
        end
        READ: begin
          if (eng_bus.gnt) begin
            state_q <= WAIT_DATA;
          end
        end
        WAIT_DATA: begin
          if (eng_bus.r_valid) begin
            state_q <= WRITE;
          end
        end
        WRITE: begin
          if (eng_bus.gnt) begin
            left_q <= left_q - 1'b1;
            if (left_q == `DMA_LEN_W'(1)) begin
              state_q        <= IDLE;
              term_q[cur_core_q] <= 1'b1;
            end else begin
              state_q <= READ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Addresses step one word per completed write
  always_ff @(posedge clk_i) begin
    if (start) begin
      src_q      <= desc_i.src;
      dst_q      <= desc_i.dst;
      cur_core_q <= desc_i.core_id;
    end else if ((state_q == WRITE) && eng_bus.gnt) begin
      src_q <= src_q + dma_pkg::addr_t'(4);
      dst_q <= dst_q + dma_pkg::addr_t'(4);
    end
    if ((state_q == WAIT_DATA) && eng_bus.r_valid) begin
      data_q <= eng_bus.r_rdata;
    end
  end

  assign eng_bus.req   = (state_q == READ) || (state_q == WRITE);
  assign eng_bus.wen   = (state_q != WRITE);
  assign eng_bus.add   = (state_q == WRITE) ? dst_q : src_q;
  assign eng_bus.wdata = data_q;

  assign term_event_o = term_q;
  assign pop_o        = |term_q;
  assign active_o     = (state_q != IDLE);

  // Memory side must only answer the single outstanding read
  a_rvalid_in_wait: assert property (
    @(posedge clk_i) disable iff (rst_i) eng_bus.r_valid |-> (state_q == WAIT_DATA)
  ) else $error("read data returned outside WAIT_DATA");

endmodule

`default_nettype wire

// ==== hw/dma_addr_router.sv ====
// DMA address router
`timescale 1ns/100ps
`default_nettype none

`include "dma_defs.svh"

module dma_addr_router (
  input  logic      clk_i,
  input  logic      rst_i,
  dma_mem_if.slave  eng_bus,
  dma_mem_if.master tcdm_bus,
  dma_mem_if.master soc_bus
);

  dma_pkg::target_e tgt;
  dma_pkg::target_e rd_tgt_q;
  logic             to_tcdm;

  // Addresses below and above the TCDM window go to SoC
  assign tgt = ((eng_bus.add >= `DMA_TCDM_BASE) &&
                (eng_bus.add < (`DMA_TCDM_BASE + `DMA_TCDM_SIZE))) ?
               dma_pkg::TGT_TCDM : dma_pkg::TGT_SOC;
  assign to_tcdm = (tgt == dma_pkg::TGT_TCDM);

  // Only the selected port sees the request
  assign tcdm_bus.req   = eng_bus.req && to_tcdm;
  assign tcdm_bus.wen   = to_tcdm ? eng_bus.wen : 1'b0;
  assign tcdm_bus.add   = to_tcdm ? eng_bus.add : '0;
  assign tcdm_bus.wdata = to_tcdm ? eng_bus.wdata : '0;

  assign soc_bus.req    = eng_bus.req && !to_tcdm;
  assign soc_bus.wen    = !to_tcdm ? eng_bus.wen : 1'b0;
  assign soc_bus.add    = !to_tcdm ? eng_bus.add : '0;
  assign soc_bus.wdata  = !to_tcdm ? eng_bus.wdata : '0;

  assign eng_bus.gnt = to_tcdm ? tcdm_bus.gnt : soc_bus.gnt;

  // Remember where the outstanding read went
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_tgt_q <= dma_pkg::TGT_SOC;
    end else if (eng_bus.req && eng_bus.wen && eng_bus.gnt) begin
      rd_tgt_q <= tgt;
    end
  end

  assign eng_bus.r_valid = (rd_tgt_q == dma_pkg::TGT_TCDM) ?
                           tcdm_bus.r_valid : soc_bus.r_valid;
  assign eng_bus.r_rdata = (rd_tgt_q == dma_pkg::TGT_TCDM) ?
                           tcdm_bus.r_rdata : soc_bus.r_rdata;

  // Read data may only come from the port that took the read
  a_rvalid_from_target: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(tcdm_bus.r_valid && (rd_tgt_q != dma_pkg::TGT_TCDM)) &&
    !(soc_bus.r_valid && (rd_tgt_q != dma_pkg::TGT_SOC))
  ) else $error("read data returned by a port that took no read");

endmodule

`default_nettype wire

// ==== hw/dma_cluster_top.sv ====
// DMA cluster subsystem top
`timescale 1ns/100ps
`default_nettype none

`include "dma_defs.svh"

module dma_cluster_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Core control ports
  input  logic [`DMA_NB_CORES-1:0]            cfg_req_i,
  input  logic [`DMA_NB_CORES-1:0]            cfg_wen_i,
  input  dma_pkg::addr_t [`DMA_NB_CORES-1:0]  cfg_add_i,
  input  dma_pkg::data_t [`DMA_NB_CORES-1:0]  cfg_wdata_i,
  output logic [`DMA_NB_CORES-1:0]            cfg_gnt_o,
  output logic [`DMA_NB_CORES-1:0]            cfg_r_valid_o,
  output dma_pkg::data_t [`DMA_NB_CORES-1:0]  cfg_r_rdata_o,
  // TCDM memory port
  output logic                                tcdm_req_o,
  output logic                                tcdm_wen_o,
  output dma_pkg::addr_t                      tcdm_add_o,
  output dma_pkg::data_t                      tcdm_wdata_o,
  input  logic                                tcdm_gnt_i,
  input  logic                                tcdm_r_valid_i,
  input  dma_pkg::data_t                      tcdm_r_rdata_i,
  // SoC memory port
  output logic                                soc_req_o,
  output logic                                soc_wen_o,
  output dma_pkg::addr_t                      soc_add_o,
  output dma_pkg::data_t                      soc_wdata_o,
  input  logic                                soc_gnt_i,
  input  logic                                soc_r_valid_i,
  input  dma_pkg::data_t                      soc_r_rdata_i,
  // Status
  output logic [`DMA_NB_CORES-1:0]            term_event_o,
  output logic                                busy_o
);

  logic           queue_full;
  logic           push;
  dma_pkg::desc_t push_desc;
  logic           queue_not_empty;
  dma_pkg::desc_t queue_head;
  logic           pop;
  logic           eng_active;

  dma_mem_if eng_bus ();
  dma_mem_if tcdm_bus ();
  dma_mem_if soc_bus ();

  dma_cfg_frontend i_cfg_frontend (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .cfg_req_i     ( cfg_req_i     ),
    .cfg_wen_i     ( cfg_wen_i     ),
    .cfg_add_i     ( cfg_add_i     ),
    .cfg_wdata_i   ( cfg_wdata_i   ),
    .cfg_gnt_o     ( cfg_gnt_o     ),
    .cfg_r_valid_o ( cfg_r_valid_o ),
    .cfg_r_rdata_o ( cfg_r_rdata_o ),
    .queue_full_i  ( queue_full    ),
    .push_o        ( push          ),
    .push_desc_o   ( push_desc     )
  );

  dma_desc_queue i_desc_queue (
    .clk_i       ( clk_i           ),
    .rst_i       ( rst_i           ),
    .push_i      ( push            ),
    .push_desc_i ( push_desc       ),
    .full_o      ( queue_full      ),
    .not_empty_o ( queue_not_empty ),
    .head_o      ( queue_head      ),
    .pop_i       ( pop             )
  );

  dma_burst_engine i_burst_engine (
    .clk_i        ( clk_i           ),
    .rst_i        ( rst_i           ),
    .desc_valid_i ( queue_not_empty ),
    .desc_i       ( queue_head      ),
    .pop_o        ( pop             ),
    .eng_bus      ( eng_bus.master  ),
    .term_event_o ( term_event_o    ),
    .active_o     ( eng_active      )
  );

  dma_addr_router i_addr_router (
    .clk_i    ( clk_i           ),
    .rst_i    ( rst_i           ),
    .eng_bus  ( eng_bus.slave   ),
    .tcdm_bus ( tcdm_bus.master ),
    .soc_bus  ( soc_bus.master  )
  );

  // Flatten the router outputs onto the memory ports
  assign tcdm_req_o       = tcdm_bus.req;
  assign tcdm_wen_o       = tcdm_bus.wen;
  assign tcdm_add_o       = tcdm_bus.add;
  assign tcdm_wdata_o     = tcdm_bus.wdata;
  assign tcdm_bus.gnt     = tcdm_gnt_i;
  assign tcdm_bus.r_valid = tcdm_r_valid_i;
  assign tcdm_bus.r_rdata = tcdm_r_rdata_i;

  assign soc_req_o        = soc_bus.req;
  assign soc_wen_o        = soc_bus.wen;
  assign soc_add_o        = soc_bus.add;
  assign soc_wdata_o      = soc_bus.wdata;
  assign soc_bus.gnt      = soc_gnt_i;
  assign soc_bus.r_valid  = soc_r_valid_i;
  assign soc_bus.r_rdata  = soc_r_rdata_i;

  assign busy_o = queue_not_empty | eng_active;

endmodule

`default_nettype wire

// ==== verif/tb_dma_cluster.sv ====
// DMA cluster testbench
`timescale 1ns/100ps
`default_nettype none

`include "dma_defs.svh"

module tb_dma_cluster;

  localparam int NB = `DMA_NB_CORES;
  localparam int MEM_WORDS = 1024;
  localparam dma_pkg::addr_t SOC_BASE = 32'h2000_0000;
  // Words moved over the whole run
  localparam int unsigned TOTAL_WORDS = 52;
  localparam int unsigned CYCLE_LIMIT = 200 + 40 * TOTAL_WORDS;

  logic                        clk_i;
  logic                        rst_i;
  logic [NB-1:0]               cfg_req_i;
  logic [NB-1:0]               cfg_wen_i;
  dma_pkg::addr_t [NB-1:0]     cfg_add_i;
  dma_pkg::data_t [NB-1:0]     cfg_wdata_i;
  logic [NB-1:0]               cfg_gnt_o;
  logic [NB-1:0]               cfg_r_valid_o;
  dma_pkg::data_t [NB-1:0]     cfg_r_rdata_o;
  logic                        tcdm_req_o;
  logic                        tcdm_wen_o;
  dma_pkg::addr_t              tcdm_add_o;
  dma_pkg::data_t              tcdm_wdata_o;
  logic                        tcdm_gnt_i = 1'b0;
  logic                        tcdm_r_valid_i = 1'b0;
  dma_pkg::data_t              tcdm_r_rdata_i = '0;
  logic                        soc_req_o;
  logic                        soc_wen_o;
  dma_pkg::addr_t              soc_add_o;
  dma_pkg::data_t              soc_wdata_o;
  logic                        soc_gnt_i = 1'b0;
  logic                        soc_r_valid_i = 1'b0;
  dma_pkg::data_t              soc_r_rdata_i = '0;
  logic [NB-1:0]               term_event_o;
  logic                        busy_o;

  // TCDM words first, then SoC words
  dma_pkg::data_t              mem [2*MEM_WORDS];
  dma_pkg::data_t              ref_mem [2*MEM_WORDS];
  dma_pkg::desc_t              launch_q [$];
  dma_pkg::addr_t              src_m [NB];
  dma_pkg::addr_t              dst_m [NB];
  logic [`DMA_LEN_W-1:0]       len_m [NB];
  int unsigned                 launch_cnt_m [NB];
  logic [31:0]                 lfsr = 32'd82456;
  int unsigned                 cycle_cnt = 0;

  dma_cluster_top i_dut (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    // Taps of x^32 + x^22 + x^2 + x + 1
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic dma_pkg::addr_t tcdm_addr(input int w);
    return `DMA_TCDM_BASE + dma_pkg::addr_t'(4 * w);
  endfunction

  function automatic dma_pkg::addr_t soc_addr(input int w);
    return SOC_BASE + dma_pkg::addr_t'(4 * w);
  endfunction

  function automatic logic in_tcdm_mem(input dma_pkg::addr_t a);
    return (a - `DMA_TCDM_BASE) < dma_pkg::addr_t'(4 * MEM_WORDS);
  endfunction

  function automatic logic in_soc_mem(input dma_pkg::addr_t a);
    return (a - SOC_BASE) < dma_pkg::addr_t'(4 * MEM_WORDS);
  endfunction

  function automatic int mem_index(input dma_pkg::addr_t a);
    return in_tcdm_mem(a) ? int'(a[11:2]) : MEM_WORDS + int'(a[11:2]);
  endfunction

  function automatic dma_pkg::data_t fill_word(input dma_pkg::addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
  endfunction

  // Reference model, one descriptor copied word by word
  function automatic void expected_copy(input dma_pkg::desc_t d);
    for (int w = 0; w < int'(d.len); w++) begin
      ref_mem[mem_index(d.dst + dma_pkg::addr_t'(4 * w))] =
        ref_mem[mem_index(d.src + dma_pkg::addr_t'(4 * w))];
    end
  endfunction

  function automatic dma_pkg::core_id_t event_core(input logic [NB-1:0] ev);
    dma_pkg::core_id_t c;
    c = '0;
    for (int i = 0; i < NB; i++) begin
      if (ev[i]) c = dma_pkg::core_id_t'(i);
    end
    return c;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_data(input string name, input dma_pkg::data_t exp,
                            input dma_pkg::data_t act);
    if (exp !== act) begin
      fail_run($sformatf("MISMATCH %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input dma_pkg::addr_t exp,
                            input dma_pkg::addr_t act);
    if (exp !== act) begin
      fail_run($sformatf("MISMATCH %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_core(input string name, input dma_pkg::core_id_t exp,
                            input dma_pkg::core_id_t act);
    if (exp !== act) begin
      fail_run($sformatf("MISMATCH %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      fail_run($sformatf("MISMATCH %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  // Mirror of the register state, launches recorded in grant order
  task automatic record_write(input int core, input dma_pkg::reg_off_e off,
                              input dma_pkg::data_t wdata);
    dma_pkg::desc_t d;
    case (off)
      dma_pkg::REG_SRC: src_m[core] = wdata;
      dma_pkg::REG_DST: dst_m[core] = wdata;
      dma_pkg::REG_LEN: len_m[core] = wdata[`DMA_LEN_W-1:0];
      dma_pkg::REG_CMD: begin
        if (len_m[core] != '0) begin
          d.src     = src_m[core];
          d.dst     = dst_m[core];
          d.len     = len_m[core];
          d.core_id = dma_pkg::core_id_t'(core);
          launch_q.push_back(d);
          launch_cnt_m[core]++;
        end
      end
      default: ;
    endcase
  endtask

  task automatic reg_access(input int core, input logic is_read, input dma_pkg::reg_off_e off,
                            input dma_pkg::data_t wdata, output dma_pkg::data_t rdata);
    rdata = '0;
    @(posedge clk_i);
    cfg_req_i[core]   <= 1'b1;
    cfg_wen_i[core]   <= is_read;
    cfg_add_i[core]   <= dma_pkg::addr_t'({off, 2'b00});
    cfg_wdata_i[core] <= wdata;
    @(posedge clk_i);
    while (!cfg_gnt_o[core]) @(posedge clk_i);
    cfg_req_i[core] <= 1'b0;
    if (!is_read) record_write(core, off, wdata);
    @(posedge clk_i);
    if (!cfg_r_valid_o[core]) begin
      fail_run($sformatf("core %0d got no response one cycle after its grant", core));
    end else begin
      rdata = cfg_r_rdata_o[core];
    end
  endtask

  task automatic write_reg(input int core, input dma_pkg::reg_off_e off,
                           input dma_pkg::data_t wdata);
    dma_pkg::data_t unused;
    reg_access(core, 1'b0, off, wdata, unused);
  endtask

  task automatic read_check(input int core, input dma_pkg::reg_off_e off,
                            input dma_pkg::addr_t exp);
    dma_pkg::data_t rdata;
    reg_access(core, 1'b1, off, '0, rdata);
    check_addr($sformatf("cfg_r_rdata_o[%0d] offset %0d", core, off), exp, rdata);
  endtask

  task automatic launch(input int core, input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
                        input int len);
    write_reg(core, dma_pkg::REG_SRC, src);
    write_reg(core, dma_pkg::REG_DST, dst);
    write_reg(core, dma_pkg::REG_LEN, dma_pkg::data_t'(len));
    write_reg(core, dma_pkg::REG_CMD, '0);
  endtask

  task automatic launch_pair(input int core);
    for (int k = 0; k < 2; k++) begin
      launch(core, soc_addr(512 + 8 * (2 * core + k)), tcdm_addr(512 + 8 * (2 * core + k)), 3);
    end
  endtask

  // busy_o stays high until the last event, then drops
  task automatic wait_done();
    while (launch_q.size() != 0) begin
      @(posedge clk_i);
      if (launch_q.size() != 0) check_flag("busy_o", 1'b1, busy_o);
    end
    @(posedge clk_i);
    check_flag("busy_o", 1'b0, busy_o);
  endtask

  task automatic compare_memories();
    for (int i = 0; i < 2 * MEM_WORDS; i++) begin
      check_data($sformatf("%s word %0d", (i < MEM_WORDS) ? "tcdm" : "soc", i % MEM_WORDS),
                 ref_mem[i], mem[i]);
    end
  endtask

  // Memory models, each port granted on its own LFSR bit
  always @(posedge clk_i) begin : memory_models
    if (rst_i) begin
      tcdm_gnt_i     <= 1'b0;
      soc_gnt_i      <= 1'b0;
      tcdm_r_valid_i <= 1'b0;
      soc_r_valid_i  <= 1'b0;
    end else begin
      tcdm_r_valid_i <= 1'b0;
      soc_r_valid_i  <= 1'b0;
      if (tcdm_req_o && tcdm_gnt_i) begin
        if (tcdm_wen_o) begin
          tcdm_r_valid_i <= 1'b1;
          tcdm_r_rdata_i <= mem[mem_index(tcdm_add_o)];
        end else begin
          mem[mem_index(tcdm_add_o)] = tcdm_wdata_o;
        end
      end
      if (soc_req_o && soc_gnt_i) begin
        if (soc_wen_o) begin
          soc_r_valid_i <= 1'b1;
          soc_r_rdata_i <= mem[mem_index(soc_add_o)];
        end else begin
          mem[mem_index(soc_add_o)] = soc_wdata_o;
        end
      end
      lfsr = lfsr_next(lfsr);
      tcdm_gnt_i <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      soc_gnt_i <= lfsr[0];
    end
  end

  always @(posedge clk_i) begin : window_check
    if (!rst_i && tcdm_req_o && !in_tcdm_mem(tcdm_add_o)) begin
      fail_run($sformatf("TCDM port accessed outside its window at 0x%h", tcdm_add_o));
    end else if (!rst_i && soc_req_o && !in_soc_mem(soc_add_o)) begin
      fail_run($sformatf("SoC port accessed outside its window at 0x%h", soc_add_o));
    end
  end

  // Events must follow launch order
  always @(posedge clk_i) begin : event_monitor
    dma_pkg::desc_t d;
    if (!rst_i && (term_event_o != '0)) begin
      if (launch_q.size() == 0) begin
        fail_run("termination event with no launched transfer pending");
      end else if (!$onehot(term_event_o)) begin
        fail_run("several termination events in the same cycle");
      end else begin
        d = launch_q.pop_front();
        check_core("term_event_o core", d.core_id, event_core(term_event_o));
        check_flag("busy_o", 1'b1, busy_o);
        expected_copy(d);
      end
    end
  end

  always @(posedge clk_i) begin : timeout_watch
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      fail_run("timeout, the run went past its cycle budget");
    end
  end

  initial begin : main_sequence
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    cfg_req_i   = '0;
    cfg_wen_i   = '0;
    cfg_add_i   = '0;
    cfg_wdata_i = '0;
    for (int c = 0; c < NB; c++) begin
      src_m[c]        = '0;
      dst_m[c]        = '0;
      len_m[c]        = '0;
      launch_cnt_m[c] = 0;
    end
    for (int i = 0; i < 2 * MEM_WORDS; i++) begin
      mem[i]     = fill_word((i < MEM_WORDS) ? tcdm_addr(i) : soc_addr(i - MEM_WORDS));
      ref_mem[i] = mem[i];
    end
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    // Registers after reset, then readback
    for (int c = 0; c < NB; c++) begin
      for (int o = 0; o <= 4; o++) begin
        read_check(c, dma_pkg::reg_off_e'(o), '0);
      end
    end
    for (int c = 0; c < NB; c++) begin
      write_reg(c, dma_pkg::REG_SRC, soc_addr(16 * c + 3));
      write_reg(c, dma_pkg::REG_DST, tcdm_addr(32 * c + 5));
      write_reg(c, dma_pkg::REG_LEN, 32'h0000_1230 + dma_pkg::data_t'(c));
      read_check(c, dma_pkg::REG_SRC, src_m[c]);
      read_check(c, dma_pkg::REG_DST, dst_m[c]);
      read_check(c, dma_pkg::REG_LEN, dma_pkg::addr_t'(len_m[c]));
    end

    // SoC to TCDM
    launch(1, soc_addr(64), tcdm_addr(16), 8);
    wait_done();
    compare_memories();

    // TCDM to SoC and TCDM to TCDM
    launch(2, tcdm_addr(100), soc_addr(200), 6);
    launch(3, tcdm_addr(300), tcdm_addr(400), 5);
    wait_done();
    compare_memories();

    // Eight launches from four cores overflow the queue
    fork
      launch_pair(0);
      launch_pair(1);
      launch_pair(2);
      launch_pair(3);
    join
    wait_done();
    compare_memories();

    // Zero length launches mixed with real ones
    launch(0, soc_addr(700), tcdm_addr(700), 0);
    repeat (4) @(posedge clk_i);
    check_flag("busy_o", 1'b0, busy_o);
    launch(0, soc_addr(710), tcdm_addr(710), 4);
    launch(0, tcdm_addr(720), soc_addr(720), 2);
    launch(2, tcdm_addr(730), tcdm_addr(740), 0);
    launch(3, soc_addr(750), soc_addr(760), 3);
    wait_done();
    compare_memories();
    for (int c = 0; c < NB; c++) begin
      read_check(c, dma_pkg::REG_STATUS, dma_pkg::addr_t'(launch_cnt_m[c]));
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dma_cluster.f ====
+incdir+include
hw/dma_pkg.sv
hw/dma_mem_if.sv
hw/dma_cfg_frontend.sv
hw/dma_desc_queue.sv
hw/dma_burst_engine.sv
hw/dma_addr_router.sv
hw/dma_cluster_top.sv
verif/tb_dma_cluster.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the DMA cluster testbench with Verilator and run it.
# The exit status is the simulation result.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dma_cluster \
  -f dma_cluster.f \
  --Mdir obj_dir -o sim_dma_cluster &&
./obj_dir/sim_dma_cluster ||
{ echo "simulation did not complete successfully" >&2; exit 1; }
